// File: common/ntt_defs.svh
//====================
// Size and modulus constants for the point-wise polynomial engine
// Include wherever a width or the modulus is needed
//====================
`ifndef NTT_DEFS_SVH
`define NTT_DEFS_SVH

// Lane width, one coefficient per lane
`define NTT_REG_SIZE 24

// Dilithium prime, 2^23 - 2^13 + 1
`define NTT_Q 8380417

// Coefficients per polynomial
`define NTT_N 256

// Coefficients packed in one memory word
`define NTT_LANES 4

// Words per polynomial
`define NTT_WORDS (`NTT_N / `NTT_LANES)

// 256-word memories
`define NTT_ADDR_WIDTH 8

`endif

// File: common/ntt_pkg.sv
//====================
// Shared types for the PWO engine, its memories and the testbench
//====================
`include "ntt_defs.svh"

package ntt_pkg;

    // Four coefficients of 24 bits
    typedef logic [`NTT_LANES-1:0][`NTT_REG_SIZE-1:0] ntt_word_t;
    typedef logic [`NTT_ADDR_WIDTH-1:0] ntt_addr_t;

    //====================
    // Enums
    //====================
    typedef enum logic [1:0] {
        MODE_PWM,
        MODE_PWA,
        MODE_PWS
    } mode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } pwo_state_t;

    // Host port memory select
    typedef enum logic [1:0] {
        MEM_A,
        MEM_B,
        MEM_C
    } mem_sel_t;

    //====================
    // Structs
    //====================
    // Polynomial start addresses
    typedef struct packed {
        ntt_addr_t base_a;
        ntt_addr_t base_b;
        ntt_addr_t base_c;
    } pwo_base_t;

    // One read or write request
    typedef struct packed {
        logic      en;
        ntt_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        mem_sel_t  sel;
        ntt_addr_t addr;
        ntt_word_t wr_data;
    } host_req_t;

    // Operands for one word, tagged with its destination
    typedef struct packed {
        logic      valid;
        logic      last;
        ntt_addr_t wr_addr;
        ntt_word_t a;
        ntt_word_t b;
        ntt_word_t c_old;
    } pwo_op_t;

    // Result write into memory C
    typedef struct packed {
        logic      valid;
        logic      last;
        ntt_addr_t addr;
        ntt_word_t data;
    } pwo_wr_t;

endpackage

// File: pwo/pwo_ctrl.sv
//====================
// Sequencer for one point-wise operation over a full polynomial
// Latches the settings on start, runs the word counter, pulses done
//====================
`timescale 1ns/1ps

module pwo_ctrl (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  ntt_pkg::mode_t mode,
    input  logic           accumulate,
    input  logic           sampler_mode,
    input  logic           sampler_valid,
    input  logic           last_issued,
    input  logic           result_last,
    output logic           busy,
    output logic           done,
    output logic           count_en,
    output logic           count_clear,
    output logic           op_valid,
    output ntt_pkg::mode_t op_mode,
    output logic           op_accumulate,
    output logic           op_sampler
);

    ntt_pkg::pwo_state_t state;

    //====================
    // State and settings
    //====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ntt_pkg::ST_IDLE;
            op_valid      <= 1'b0;
            op_mode       <= ntt_pkg::MODE_PWM;
            op_accumulate <= 1'b0;
            op_sampler    <= 1'b0;
        end else begin
            // Read data lands one cycle after the request
            op_valid <= count_en;
            case (state)
                ntt_pkg::ST_IDLE: begin
                    if (start) begin
                        state         <= ntt_pkg::ST_RUN;
                        op_mode       <= mode;
                        op_accumulate <= accumulate;
                        op_sampler    <= sampler_mode;
                    end
                end
                ntt_pkg::ST_RUN: begin
                    // 64th word requested, only the pipeline is left
                    if (last_issued) begin
                        state <= ntt_pkg::ST_DRAIN;
                    end
                end
                ntt_pkg::ST_DRAIN: begin
                    if (result_last) begin
                        state <= ntt_pkg::ST_IDLE;
                    end
                end
                default: state <= ntt_pkg::ST_IDLE;
            endcase
        end
    end

    // Counter restarts at word 0 on an accepted start
    assign count_clear = (state == ntt_pkg::ST_IDLE) && start;

    // Stream gaps hold the counter in sampler mode
    assign count_en = (state == ntt_pkg::ST_RUN) && (!op_sampler || sampler_valid);

    assign busy = (state != ntt_pkg::ST_IDLE);

    // Last result write goes out in the same cycle
    assign done = (state == ntt_pkg::ST_DRAIN) && result_last;

    //====================
    // Checks
    //====================
    // Pipeline is empty by the time done fires
    a_done_drain: assert property (@(posedge clk) disable iff (reset)
        done |-> (state == ntt_pkg::ST_DRAIN) && !op_valid);

    // Nothing issued or in flight at the memories while idle
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == ntt_pkg::ST_IDLE) |-> !count_en && !op_valid);

endmodule

// File: pwo/pwo_addr_gen.sv
//====================
// Word counter issuing reads to A, B and C at base plus index
// Tags are delayed one cycle to line up with read data
//====================
`timescale 1ns/1ps
`include "ntt_defs.svh"

module pwo_addr_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                count_en,
    input  logic                count_clear,
    input  ntt_pkg::pwo_base_t  base,
    input  ntt_pkg::ntt_word_t  sampler_data,
    output ntt_pkg::mem_req_t   rd_a,
    output ntt_pkg::mem_req_t   rd_b,
    output ntt_pkg::mem_req_t   rd_c,
    output logic                last_issued,
    output ntt_pkg::ntt_addr_t  tag_wr_addr,
    output logic                tag_last,
    output ntt_pkg::ntt_word_t  tag_sampler
);

    localparam int IDX_W = $clog2(`NTT_WORDS);

    logic [IDX_W-1:0]   index;
    ntt_pkg::ntt_addr_t index_ext;
    ntt_pkg::pwo_base_t base_q;

    // Word index, wraps back to 0 after the last word
    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (count_clear) begin
            index <= '0;
        end else if (count_en) begin
            index <= index + 1'b1;
        end
    end

    // Bases held for the whole run
    always_ff @(posedge clk) begin
        if (count_clear) begin
            base_q <= base;
        end
    end

    assign index_ext = ntt_pkg::ntt_addr_t'(index);

    assign rd_a.en   = count_en;
    assign rd_a.addr = base_q.base_a + index_ext;
    assign rd_b.en   = count_en;
    assign rd_b.addr = base_q.base_b + index_ext;
    // C read fetches the old word for accumulate, same address gets the result
    assign rd_c.en   = count_en;
    assign rd_c.addr = base_q.base_c + index_ext;

    assign last_issued = count_en && (index == IDX_W'(`NTT_WORDS - 1));

    //====================
    // Tags, one cycle behind the requests
    //====================
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_last <= 1'b0;
        end else begin
            tag_last <= last_issued;
        end
    end

    always_ff @(posedge clk) begin
        if (count_en) begin
            tag_wr_addr <= rd_c.addr;
            // Stream word taken in the cycle it was accepted
            tag_sampler <= sampler_data;
        end
    end

endmodule

// File: pwo/pwo_arith.sv
//====================
// Four-lane modular add, subtract and multiply, two pipeline stages
// Result is valid two cycles after op.valid
//====================
`timescale 1ns/1ps
`include "ntt_defs.svh"

module pwo_arith (
    input  logic              clk,
    input  logic              reset,
    input  ntt_pkg::pwo_op_t  op,
    input  ntt_pkg::mode_t    mode,
    input  logic              accumulate,
    input  logic              sampler,
    output ntt_pkg::pwo_wr_t  result
);

    localparam logic [`NTT_REG_SIZE-1:0] Q = `NTT_REG_SIZE'(`NTT_Q);
    // 2^23 mod Q, the fold factor for the high part
    localparam int FOLD = (1 << 23) - `NTT_Q;

    ntt_pkg::ntt_word_t b_sel;
    logic [`NTT_LANES-1:0][45:0] s1_next;
    logic [`NTT_LANES-1:0][45:0] s1_val;
    ntt_pkg::ntt_word_t s1_c_old;
    ntt_pkg::ntt_addr_t s1_addr;
    logic               s1_valid;
    logic               s1_last;
    logic [`NTT_LANES-1:0][22:0] red;
    ntt_pkg::ntt_word_t res_next;

    // Three folds of 2^23 == FOLD, then one conditional subtract
    function automatic logic [22:0] mod_q(input logic [45:0] x);
        logic [36:0] y;
        logic [27:0] z;
        logic [23:0] w;
        y = 37'(x[45:23]) * 37'(FOLD) + 37'(x[22:0]);
        z = 28'(y[36:23]) * 28'(FOLD) + 28'(y[22:0]);
        w = 24'(z[27:23]) * 24'(FOLD) + 24'(z[22:0]);
        if (w >= Q) begin
            w = w - Q;
        end
        return w[22:0];
    endfunction

    //====================
    // Stage 1
    //====================
    always_comb begin
        for (int i = 0; i < `NTT_LANES; i++) begin
            // Stream words may sit in [Q, 2Q), memory words are already reduced
            if (sampler && (op.b[i] >= Q)) begin
                b_sel[i] = op.b[i] - Q;
            end else begin
                b_sel[i] = op.b[i];
            end
            case (mode)
                ntt_pkg::MODE_PWA: s1_next[i] = 46'(op.a[i]) + 46'(b_sel[i]);
                // Bias by Q so a < b stays positive
                ntt_pkg::MODE_PWS: s1_next[i] = 46'(op.a[i]) + 46'(Q) - 46'(b_sel[i]);
                default:           s1_next[i] = op.a[i][22:0] * b_sel[i][22:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= op.valid;
            s1_last  <= op.valid && op.last;
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            s1_val   <= s1_next;
            s1_c_old <= op.c_old;
            s1_addr  <= op.wr_addr;
        end
    end

    //====================
    // Stage 2
    //====================
    always_comb begin
        for (int i = 0; i < `NTT_LANES; i++) begin
            red[i] = mod_q(s1_val[i]);
            res_next[i] = {1'b0, red[i]};
            // Accumulate only applies to pwm, sum stays below 2Q
            if ((mode == ntt_pkg::MODE_PWM) && accumulate) begin
                res_next[i] = {1'b0, red[i]} + {1'b0, s1_c_old[i][22:0]};
                if (res_next[i] >= Q) begin
                    res_next[i] = res_next[i] - Q;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
            result.last  <= 1'b0;
        end else begin
            result.valid <= s1_valid;
            result.last  <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result.addr <= s1_addr;
            result.data <= res_next;
        end
    end

    // Fixed two-cycle latency, no bubbles created or lost
    a_latency: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> $past(op.valid, 2));

endmodule

// File: logic/ntt_ram.sv
//====================
// Coefficient memory with engine read/write and a host port
// Host read data passes down a chain, the addressed memory drives it
//====================
`timescale 1ns/1ps
`include "ntt_defs.svh"

module ntt_ram #(
    parameter ntt_pkg::mem_sel_t MEM_ID = ntt_pkg::MEM_A
) (
    input  logic                clk,
    input  logic                reset,
    input  ntt_pkg::mem_req_t   rd,
    input  ntt_pkg::pwo_wr_t    wr,
    input  ntt_pkg::host_req_t  host,
    input  ntt_pkg::ntt_word_t  host_rd_in,
    output ntt_pkg::ntt_word_t  rd_data,
    output ntt_pkg::ntt_word_t  host_rd_out
);

    localparam int DEPTH = 1 << `NTT_ADDR_WIDTH;

    ntt_pkg::ntt_word_t mem [DEPTH];
    ntt_pkg::ntt_word_t host_word;
    logic               host_hit;
    logic               host_sel_q;

    assign host_hit = (host.sel == MEM_ID);

    // Single write port, engine and host never meet here
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end else if (host.wr_en && host_hit) begin
            mem[host.addr] <= host.wr_data;
        end
    end

    // Engine read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (host.rd_en && host_hit) begin
            host_word <= mem[host.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            host_sel_q <= 1'b0;
        end else begin
            host_sel_q <= host.rd_en && host_hit;
        end
    end

    assign host_rd_out = host_sel_q ? host_word : host_rd_in;

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !(wr.valid && host.wr_en && host_hit));

    // Host may only touch this memory while the engine is not reading it
    a_host_idle: assert property (@(posedge clk) disable iff (reset)
        rd.en |-> !(host_hit && (host.wr_en || host.rd_en)));

endmodule

// File: logic/ntt_pwo_top.sv
//====================
// PWO engine top: controller, counter, datapath and memories A, B, C
//====================
`timescale 1ns/1ps

module ntt_pwo_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ntt_pkg::mode_t      mode,
    input  logic                accumulate,
    input  ntt_pkg::pwo_base_t  base,
    input  logic                sampler_mode,
    input  logic                sampler_valid,
    input  ntt_pkg::ntt_word_t  sampler_data,
    input  ntt_pkg::host_req_t  host,
    output ntt_pkg::ntt_word_t  host_rd_data,
    output logic                busy,
    output logic                done
);

    logic               count_en;
    logic               count_clear;
    logic               op_valid;
    ntt_pkg::mode_t     op_mode;
    logic               op_accumulate;
    logic               op_sampler;
    logic               last_issued;
    ntt_pkg::mem_req_t  rd_a;
    ntt_pkg::mem_req_t  rd_b;
    ntt_pkg::mem_req_t  rd_c;
    ntt_pkg::ntt_addr_t tag_wr_addr;
    logic               tag_last;
    ntt_pkg::ntt_word_t tag_sampler;
    ntt_pkg::ntt_word_t a_rd_data;
    ntt_pkg::ntt_word_t b_rd_data;
    ntt_pkg::ntt_word_t c_rd_data;
    ntt_pkg::ntt_word_t host_ab;
    ntt_pkg::ntt_word_t host_bc;
    ntt_pkg::pwo_op_t   op;
    ntt_pkg::pwo_wr_t   result;

    pwo_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .mode          (mode),
        .accumulate    (accumulate),
        .sampler_mode  (sampler_mode),
        .sampler_valid (sampler_valid),
        .last_issued   (last_issued),
        .result_last   (result.last),
        .busy          (busy),
        .done          (done),
        .count_en      (count_en),
        .count_clear   (count_clear),
        .op_valid      (op_valid),
        .op_mode       (op_mode),
        .op_accumulate (op_accumulate),
        .op_sampler    (op_sampler)
    );

    pwo_addr_gen u_addr (
        .clk          (clk),
        .reset        (reset),
        .count_en     (count_en),
        .count_clear  (count_clear),
        .base         (base),
        .sampler_data (sampler_data),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .rd_c         (rd_c),
        .last_issued  (last_issued),
        .tag_wr_addr  (tag_wr_addr),
        .tag_last     (tag_last),
        .tag_sampler  (tag_sampler)
    );

    // Operand bundle, B taken from the stream in sampler mode
    assign op.valid   = op_valid;
    assign op.last    = tag_last;
    assign op.wr_addr = tag_wr_addr;
    assign op.a       = a_rd_data;
    assign op.b       = op_sampler ? tag_sampler : b_rd_data;
    assign op.c_old   = c_rd_data;

    pwo_arith u_arith (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .mode       (op_mode),
        .accumulate (op_accumulate),
        .sampler    (op_sampler),
        .result     (result)
    );

    // A and B are read-only for the engine
    ntt_ram #(.MEM_ID(ntt_pkg::MEM_A)) u_mem_a (
        .clk         (clk),
        .reset       (reset),
        .rd          (rd_a),
        .wr          ('0),
        .host        (host),
        .host_rd_in  ('0),
        .rd_data     (a_rd_data),
        .host_rd_out (host_ab)
    );

    ntt_ram #(.MEM_ID(ntt_pkg::MEM_B)) u_mem_b (
        .clk         (clk),
        .reset       (reset),
        .rd          (rd_b),
        .wr          ('0),
        .host        (host),
        .host_rd_in  (host_ab),
        .rd_data     (b_rd_data),
        .host_rd_out (host_bc)
    );

    ntt_ram #(.MEM_ID(ntt_pkg::MEM_C)) u_mem_c (
        .clk         (clk),
        .reset       (reset),
        .rd          (rd_c),
        .wr          (result),
        .host        (host),
        .host_rd_in  (host_bc),
        .rd_data     (c_rd_data),
        .host_rd_out (host_rd_data)
    );

endmodule

// File: dv/ntt_pwo_tb.sv
//====================
// Testbench for the PWO engine top that loads memories over the host port
// Runs pwa, pws, pwm, accumulate and sampler operations against a model
//====================
`timescale 1ns/1ps
`include "ntt_defs.svh"

module ntt_pwo_tb;

    // Enough for every test below with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DEPTH = 1 << `NTT_ADDR_WIDTH;

    logic                clk = 1'b0;
    logic                reset;
    logic                start;
    ntt_pkg::mode_t      mode;
    logic                accumulate;
    ntt_pkg::pwo_base_t  base;
    logic                sampler_mode;
    logic                sampler_valid;
    ntt_pkg::ntt_word_t  sampler_data;
    ntt_pkg::host_req_t  host;
    ntt_pkg::ntt_word_t  host_rd_data;
    logic                busy;
    logic                done;

    integer seed = 30;
    int     cycle_count = 0;
    int     error_count = 0;

    // Model memories and the sampler stream
    ntt_pkg::ntt_word_t model_a [DEPTH];
    ntt_pkg::ntt_word_t model_b [DEPTH];
    ntt_pkg::ntt_word_t model_c [DEPTH];
    ntt_pkg::ntt_word_t stream [`NTT_WORDS];

    ntt_pwo_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .mode          (mode),
        .accumulate    (accumulate),
        .base          (base),
        .sampler_mode  (sampler_mode),
        .sampler_valid (sampler_valid),
        .sampler_data  (sampler_data),
        .host          (host),
        .host_rd_data  (host_rd_data),
        .busy          (busy),
        .done          (done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, done never came", cycle_count);
            $display("test failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    //====================
    // Reference and compare
    //====================
    // Expected word lane by lane from the modular rules
    function automatic ntt_pkg::ntt_word_t ref_word(input ntt_pkg::mode_t m, input logic acc,
            input ntt_pkg::ntt_word_t a, input ntt_pkg::ntt_word_t b,
            input ntt_pkg::ntt_word_t c_old);
        ntt_pkg::ntt_word_t r;
        longint q;
        longint x;
        longint y;
        longint p;
        int     i;
        q = `NTT_Q;
        for (i = 0; i < `NTT_LANES; i++) begin
            x = longint'(a[i]);
            y = longint'(b[i]);
            case (m)
                ntt_pkg::MODE_PWA: r[i] = 24'((x + y) % q);
                ntt_pkg::MODE_PWS: r[i] = 24'((x - y + q) % q);
                default: begin
                    p = (x * y) % q;
                    if (acc) begin
                        p = (longint'(c_old[i]) + p) % q;
                    end
                    r[i] = 24'(p);
                end
            endcase
        end
        return r;
    endfunction

    function automatic ntt_pkg::ntt_word_t rand_word();
        ntt_pkg::ntt_word_t w;
        int i;
        for (i = 0; i < `NTT_LANES; i++) begin
            w[i] = 24'($unsigned($random(seed)) % `NTT_Q);
        end
        return w;
    endfunction

    function automatic ntt_pkg::pwo_base_t make_base(input ntt_pkg::ntt_addr_t a,
            input ntt_pkg::ntt_addr_t b, input ntt_pkg::ntt_addr_t c);
        ntt_pkg::pwo_base_t r;
        r.base_a = a;
        r.base_b = b;
        r.base_c = c;
        return r;
    endfunction

    task automatic check_word(input ntt_pkg::ntt_word_t got, input ntt_pkg::ntt_word_t exp,
            input string name);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string name);
        if (got != exp) begin
            error_count++;
            $display("error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    //====================
    // Host port
    //====================
    // Drives one write and records it in the model
    task automatic write_word(input ntt_pkg::mem_sel_t sel, input ntt_pkg::ntt_addr_t addr,
            input ntt_pkg::ntt_word_t data);
        @(posedge clk);
        host.wr_en   <= 1'b1;
        host.rd_en   <= 1'b0;
        host.sel     <= sel;
        host.addr    <= addr;
        host.wr_data <= data;
        case (sel)
            ntt_pkg::MEM_A: model_a[addr] = data;
            ntt_pkg::MEM_B: model_b[addr] = data;
            default:        model_c[addr] = data;
        endcase
    endtask

    task automatic host_release();
        @(posedge clk);
        host <= '0;
    endtask

    // Data sampled one cycle after the DUT sees rd_en
    task automatic read_word(input ntt_pkg::mem_sel_t sel, input ntt_pkg::ntt_addr_t addr,
            output ntt_pkg::ntt_word_t got);
        @(posedge clk);
        host.wr_en <= 1'b0;
        host.rd_en <= 1'b1;
        host.sel   <= sel;
        host.addr  <= addr;
        @(posedge clk);
        host.rd_en <= 1'b0;
        @(posedge clk);
        got = host_rd_data;
    endtask

    // Fill all three memories and read every word back
    task automatic load_and_verify();
        ntt_pkg::ntt_word_t got;
        int i;
        for (i = 0; i < DEPTH; i++) begin
            write_word(ntt_pkg::MEM_A, 8'(i), rand_word());
            write_word(ntt_pkg::MEM_B, 8'(i), rand_word());
            write_word(ntt_pkg::MEM_C, 8'(i), rand_word());
        end
        host_release();
        for (i = 0; i < DEPTH; i++) begin
            read_word(ntt_pkg::MEM_A, 8'(i), got);
            check_word(got, model_a[i], $sformatf("mem_a[%0d]", i));
            read_word(ntt_pkg::MEM_B, 8'(i), got);
            check_word(got, model_b[i], $sformatf("mem_b[%0d]", i));
            read_word(ntt_pkg::MEM_C, 8'(i), got);
            check_word(got, model_c[i], $sformatf("mem_c[%0d]", i));
        end
    endtask

    //====================
    // Engine runs
    //====================
    // n counts edges from the one that samples start
    task automatic run_op(input ntt_pkg::mode_t m, input logic acc, input ntt_pkg::pwo_base_t b,
            input logic smode, input int gap_pct, input logic restart,
            output int n, output int stalls);
        int  k;
        logic seen_done;
        k = 0;
        stalls = 0;
        seen_done = 1'b0;
        @(posedge clk);
        start        <= 1'b1;
        mode         <= m;
        accumulate   <= acc;
        base         <= b;
        sampler_mode <= smode;
        sampler_valid <= smode && (($unsigned($random(seed)) % 100) >= gap_pct);
        sampler_data <= stream[0];
        n = -1;
        while (!seen_done) begin
            @(posedge clk);
            n++;
            if (n == 0) begin
                start <= 1'b0;
                check_bit(busy, 1'b0, "busy");
            end
            if (n >= 1) begin
                check_bit(busy, 1'b1, "busy");
            end
            // A word goes in on every running edge unless the stream is empty
            if ((n >= 1) && (k < `NTT_WORDS)) begin
                if (!smode || sampler_valid) begin
                    k++;
                end else begin
                    stalls++;
                end
            end
            if (done) begin
                seen_done = 1'b1;
            end
            // Second start while busy with other settings
            if (restart && (n == 10)) begin
                start <= 1'b1;
                mode  <= ntt_pkg::MODE_PWS;
            end
            if (restart && (n == 11)) begin
                start <= 1'b0;
            end
            if (smode && (k < `NTT_WORDS)) begin
                sampler_valid <= (($unsigned($random(seed)) % 100) >= gap_pct);
                sampler_data  <= stream[k];
            end else begin
                sampler_valid <= 1'b0;
            end
        end
        @(posedge clk);
        check_bit(done, 1'b0, "done");
        check_bit(busy, 1'b0, "busy");
    endtask

    task automatic run_check(input ntt_pkg::mode_t m, input logic acc, input ntt_pkg::pwo_base_t b,
            input logic smode, input int gap_pct, input logic restart);
        ntt_pkg::ntt_word_t got;
        ntt_pkg::ntt_word_t bw;
        ntt_pkg::ntt_addr_t aa;
        ntt_pkg::ntt_addr_t ab;
        ntt_pkg::ntt_addr_t ac;
        int n;
        int stalls;
        int i;
        run_op(m, acc, b, smode, gap_pct, restart, n, stalls);
        check_cycles(n, 67 + stalls, "done latency");
        // Ignored start must leave no second run and no second done behind
        if (restart) begin
            repeat (80) begin
                @(posedge clk);
                check_bit(done, 1'b0, "done");
                check_bit(busy, 1'b0, "busy");
            end
        end
        for (i = 0; i < `NTT_WORDS; i++) begin
            aa = ntt_pkg::ntt_addr_t'(b.base_a + i);
            ab = ntt_pkg::ntt_addr_t'(b.base_b + i);
            ac = ntt_pkg::ntt_addr_t'(b.base_c + i);
            bw = smode ? stream[i] : model_b[ab];
            model_c[ac] = ref_word(m, acc, model_a[aa], bw, model_c[ac]);
        end
        for (i = 0; i < `NTT_WORDS; i++) begin
            ac = ntt_pkg::ntt_addr_t'(b.base_c + i);
            read_word(ntt_pkg::MEM_C, ac, got);
            check_word(got, model_c[ac], $sformatf("mem_c[%0d]", ac));
        end
    endtask

    //====================
    // Test sequence
    //====================
    initial begin
        int i;
        reset         <= 1'b1;
        start         <= 1'b0;
        mode          <= ntt_pkg::MODE_PWM;
        accumulate    <= 1'b0;
        base          <= '0;
        sampler_mode  <= 1'b0;
        sampler_valid <= 1'b0;
        sampler_data  <= '0;
        host          <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_bit(busy, 1'b0, "busy");
        check_bit(done, 1'b0, "done");

        load_and_verify();

        run_check(ntt_pkg::MODE_PWA, 1'b0, make_base(8'h10, 8'h40, 8'h80), 1'b0, 0, 1'b0);

        // Edge lanes for the subtract wrap with a = 0 against b = Q-1
        write_word(ntt_pkg::MEM_A, 8'h20, {24'd0, 24'd5, 24'd1, 24'd0});
        write_word(ntt_pkg::MEM_B, 8'h90, {24'(`NTT_Q - 1), 24'd5, 24'd2, 24'(`NTT_Q - 1)});
        host_release();
        run_check(ntt_pkg::MODE_PWS, 1'b0, make_base(8'h20, 8'h90, 8'h08), 1'b0, 0, 1'b0);

        run_check(ntt_pkg::MODE_PWM, 1'b0, make_base(8'h00, 8'h00, 8'hc0), 1'b0, 0, 1'b0);
        run_check(ntt_pkg::MODE_PWM, 1'b1, make_base(8'h40, 8'h80, 8'hc0), 1'b0, 0, 1'b0);

        // Stream B with about 40 percent gaps
        for (i = 0; i < `NTT_WORDS; i++) begin
            stream[i] = rand_word();
        end
        run_check(ntt_pkg::MODE_PWM, 1'b0, make_base(8'h30, 8'h30, 8'h50), 1'b1, 40, 1'b0);

        // Start during busy is ignored
        run_check(ntt_pkg::MODE_PWA, 1'b0, make_base(8'h60, 8'h20, 8'h10), 1'b0, 0, 1'b1);

        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+common
common/ntt_pkg.sv
pwo/pwo_ctrl.sv
pwo/pwo_addr_gen.sv
pwo/pwo_arith.sv
logic/ntt_ram.sv
logic/ntt_pwo_top.sv
dv/ntt_pwo_tb.sv
